// File: mips_cpu.f
+incdir+verification
design/mips_pkg.sv
design/ctrl_if.sv
design/control_unit.sv
design/alu.sv
design/register_file.sv
design/hi_lo_unit.sv
design/program_counter.sv
design/mips_cpu.sv
verification/mips_cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build the mips_cpu testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f mips_cpu.f --top-module mips_cpu_tb -o mips_cpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/mips_cpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
fi
exit $status

// File: verification/mips_cpu_program.svh
	localparam int PROGRAM_WORDS = 68;
	localparam logic [31:0] PROGRAM_BYTES = 32'h0000_0110;
	localparam logic [31:0] PROGRAM [PROGRAM_WORDS] = '{ // Word 0x000 upward, two per line
		32'h8C01_0000, 32'h8C02_0004, // lw $1,0($0); lw $2,4($0)
		32'h0022_1821, 32'hAC03_0100, // addu $3,$1,$2; sw $3,0x100
		32'h0022_1823, 32'hAC03_0104, // subu
		32'h0022_1824, 32'hAC03_0108, // and
		32'h0022_1825, 32'hAC03_010C, // or
		32'h0022_1826, 32'hAC03_0110, // xor
		32'h0022_1827, 32'hAC03_0114, // nor
		32'h0022_182A, 32'hAC03_0118, // slt
		32'h0022_182B, 32'hAC03_011C, // sltu
		32'h0001_18C0, 32'hAC03_0120, // sll $3,$1,3
		32'h0002_18C2, 32'hAC03_0124, // srl $3,$2,3
		32'h0002_18C3, 32'hAC03_0128, // sra $3,$2,3
		32'h2423_8001, 32'hAC03_012C, // addiu $3,$1,0x8001
		32'h2823_8001, 32'hAC03_0130, // slti
		32'h2C23_8001, 32'hAC03_0134, // sltiu
		32'h3023_8001, 32'hAC03_0138, // andi
		32'h3423_8001, 32'hAC03_013C, // ori
		32'h3823_8001, 32'hAC03_0140, // xori
		32'h3C03_8001, 32'hAC03_0144, // lui $3,0x8001
		32'h0022_0018, 32'h0000_1810, // mult $1,$2; mfhi $3
		32'hAC03_0148, 32'h0000_1812, // sw 0x148; mflo $3
		32'hAC03_014C, 32'h0022_0019, // sw 0x14C; multu $1,$2
		32'h0000_1810, 32'hAC03_0150, // mfhi $3; sw 0x150
		32'h0000_1812, 32'hAC03_0154, // mflo $3; sw 0x154
		32'h2405_0001, 32'h10A5_0001, // addiu $5,$0,1; beq $5,$5 taken
		32'hAC03_01F0, 32'h10A0_0001, // skipped sw; beq $5,$0 falls through
		32'h3484_0001, 32'h14A0_0001, // ori $4,$4,1; bne $5,$0 taken
		32'hAC03_01F4, 32'h14A5_0001, // skipped sw; bne $5,$5 falls through
		32'h3484_0002, 32'h0C00_003C, // ori $4,$4,2; jal 0x0F0 at 0x0E4
		32'h0800_003E, 32'hAC03_01F8, // j 0x0F8; skipped sw
		32'h3484_0004, 32'h03E0_0008, // Subroutine: ori $4,$4,4; jr $31
		32'h3484_0008, 32'h24A0_7FFF, // ori $4,$4,8; addiu $0,$5,0x7FFF
		32'hAC1F_0158, 32'hAC04_015C, // sw $31,0x158; sw $4,0x15C
		32'hAC00_0160, 32'h0800_0043  // sw $0,0x160; j to itself
	};

// File: verification/mips_cpu_tb.sv
`timescale 1ns/100ps

module mips_cpu_tb;
	`include "mips_cpu_program.svh"

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;
	localparam logic [31:0] STORE_BASE = 32'h0000_0100;
	localparam int CYCLE_LIMIT = 200;

	logic        clk;
	logic        rst;
	logic [31:0] instr_address;
	logic [31:0] instruction;
	logic [31:0] data_address;
	logic [31:0] data_writedata;
	logic        data_write;
	logic [31:0] data_readdata;

	logic [31:0] ram [256];
	logic [31:0] exp_data [$];
	string       exp_name [$];
	int          store_index = 0;
	int          cycles_out_of_reset = 0;
	logic [31:0] seed;
	logic [31:0] op_a;
	logic [31:0] op_b;

	mips_cpu #(.RESET_VECTOR(RESET_VECTOR)) UUT (
		.clk(clk),
		.rst(rst),
		.instr_address(instr_address),
		.instruction(instruction),
		.data_address(data_address),
		.data_writedata(data_writedata),
		.data_write(data_write),
		.data_readdata(data_readdata)
	);

	assign instruction = (instr_address < PROGRAM_BYTES) ? PROGRAM[instr_address[8:2]] :
		32'h0000_0000;
	assign data_readdata = ram[data_address[9:2]];

	always @(posedge clk) begin
		if (data_write) begin
			ram[data_address[9:2]] = data_writedata;
		end
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic report_mismatch(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED %s expected %h actual %h", test, expected, actual);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic report_error(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic expect_store(input string name, input logic [31:0] data);
		exp_name.push_back(name);
		exp_data.push_back(data);
	endtask

	// Store order follows the program layout from 0x100 upward
	task automatic build_expected_stores(input logic [31:0] a, input logic [31:0] b);
		logic [31:0] imm;
		logic [63:0] sprod;
		logic [63:0] uprod;
		imm = 32'hFFFF_8001; // 0x8001 sign extended
		sprod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
		uprod = {32'h0000_0000, a} * {32'h0000_0000, b};
		expect_store("addu", a + b);
		expect_store("subu", a - b);
		expect_store("and", a & b);
		expect_store("or", a | b);
		expect_store("xor", a ^ b);
		expect_store("nor", ~(a | b));
		expect_store("slt", ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		expect_store("sltu", (a < b) ? 32'd1 : 32'd0);
		expect_store("sll", {a[28:0], 3'b000});
		expect_store("srl", {3'b000, b[31:3]});
		expect_store("sra", {{3{b[31]}}, b[31:3]});
		expect_store("addiu", a + imm);
		expect_store("slti", ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0);
		expect_store("sltiu", (a < imm) ? 32'd1 : 32'd0);
		expect_store("andi", a & 32'h0000_8001);
		expect_store("ori", a | 32'h0000_8001);
		expect_store("xori", a ^ 32'h0000_8001);
		expect_store("lui", 32'h8001_0000);
		expect_store("mult_hi", sprod[63:32]);
		expect_store("mult_lo", sprod[31:0]);
		expect_store("multu_hi", uprod[63:32]);
		expect_store("multu_lo", uprod[31:0]);
		expect_store("jal_link", 32'h0000_00E4 + 32'd4); // jal sits at 0x0E4
		expect_store("path_marker", 32'h0000_000F);
		expect_store("zero_register", 32'h0000_0000);
	endtask

	always @(negedge clk) begin
		if (rst) begin
			assert (instr_address == RESET_VECTOR)
				else report_error("instr_address left the reset vector during reset");
			assert (!data_write) else report_error("data_write went high during reset");
		end else begin
			if (cycles_out_of_reset == 0) begin
				assert (instr_address == RESET_VECTOR)
					else report_mismatch("reset_vector", RESET_VECTOR, instr_address);
			end
			cycles_out_of_reset++;
			if (data_write) begin
				assert (store_index < exp_data.size())
					else report_error("store seen after the last expected store");
				assert (data_address == STORE_BASE + 32'(4 * store_index))
					else report_mismatch({exp_name[store_index], " address"},
						STORE_BASE + 32'(4 * store_index), data_address);
				assert (data_writedata == exp_data[store_index])
					else report_mismatch(exp_name[store_index], exp_data[store_index],
						data_writedata);
				store_index++;
			end
		end
	end

	initial begin
		int cycles;
		rst = 1'b1;
		for (int i = 0; i < 256; i++) begin
			ram[i] = 32'hDEAD_0000 | 32'(i << 2);
		end
		seed = lcg_next(32'd21);
		op_a = seed;
		seed = lcg_next(seed);
		op_b = seed;
		ram[0] = op_a; // Operand A at 0x0
		ram[1] = op_b; // Operand B at 0x4
		build_expected_stores(op_a, op_b);
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		cycles = 0;
		while (store_index < exp_data.size() && cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (store_index == exp_data.size()) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("timeout after %0d stores of %0d", store_index, exp_data.size());
			$display("TESTS FAILED");
			$fatal(1, "stopped on timeout");
		end
	end
endmodule

// File: design/mips_cpu.sv
`timescale 1ns/100ps

module mips_cpu #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] instr_address,
	input  logic [31:0] instruction,
	output logic [31:0] data_address,
	output logic [31:0] data_writedata,
	output logic        data_write,
	input  logic [31:0] data_readdata
);
	mips_pkg::instr_word_t instr;
	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] reg_a;
	logic [31:0] reg_b;
	logic [31:0] imm_ext;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic [31:0] hi_lo_value;
	logic [31:0] write_data;
	logic [4:0]  write_reg;
	logic [4:0]  alu_shamt;
	logic        equal;

	assign instr = instruction;

	ctrl_if ctrl (.clk(clk), .rst(rst));

	control_unit u_control (
		.instruction(instr),
		.ctrl(ctrl.decode)
	);

	register_file u_regs (
		.clk(clk),
		.rst(rst),
		.read_reg_a(instr.r_view.rs),
		.read_reg_b(instr.r_view.rt),
		.write_reg(write_reg),
		.write_enable(ctrl.register_write),
		.write_data(write_data),
		.read_data_a(reg_a),
		.read_data_b(reg_b)
	);

	assign imm_ext = ctrl.zero_extend ? {16'h0000, instr.i_view.imm16} :
		{{16{instr.i_view.imm16[15]}}, instr.i_view.imm16};
	assign alu_shamt = ctrl.alu_src_a_shamt ? instr.r_view.shamt : reg_a[4:0];

	always_comb begin
		case (ctrl.alu_src_b)
			mips_pkg::SRC_B_REG: alu_b = reg_b;
			mips_pkg::SRC_B_IMM: alu_b = imm_ext;
			mips_pkg::SRC_B_PC4: alu_b = pc_plus4;
			default:             alu_b = 32'h0000_0000;
		endcase
		case (ctrl.register_destination)
			mips_pkg::DEST_RT: write_reg = instr.i_view.rt;
			mips_pkg::DEST_RD: write_reg = instr.r_view.rd;
			mips_pkg::DEST_RA: write_reg = 5'd31;
			default:           write_reg = 5'd0;
		endcase
	end

	alu u_alu (
		.a(reg_a),
		.b(alu_b),
		.shamt(alu_shamt),
		.op(ctrl.alu_op),
		.result(alu_result),
		.equal(equal)
	);

	hi_lo_unit u_hi_lo (
		.clk(clk),
		.rst(rst),
		.a(reg_a),
		.b(reg_b),
		.ctrl(ctrl.use_side),
		.hi_lo_value(hi_lo_value)
	);

	program_counter #(.RESET_VECTOR(RESET_VECTOR)) u_pc (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl.use_side),
		.instruction(instr),
		.register_target(reg_a), // jr and jalr target in rs
		.equal(equal),
		.pc(pc),
		.pc_plus4(pc_plus4)
	);

	always_comb begin
		if (ctrl.link) begin
			write_data = pc_plus4; // Return address, no delay slot
		end else if (ctrl.memory_to_register) begin
			write_data = data_readdata;
		end else if (ctrl.read_hi_lo) begin
			write_data = hi_lo_value;
		end else begin
			write_data = alu_result;
		end
	end

	assign instr_address  = pc;
	assign data_address   = alu_result;
	assign data_writedata = reg_b;
	assign data_write     = ctrl.memory_write;
endmodule

// File: design/program_counter.sv
`timescale 1ns/100ps

module program_counter #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
	input  logic                  clk,
	input  logic                  rst,
	ctrl_if.use_side              ctrl,
	input  mips_pkg::instr_word_t instruction,
	input  logic [31:0]           register_target,
	input  logic                  equal,
	output logic [31:0]           pc,
	output logic [31:0]           pc_plus4
);
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] next_pc;
	logic        take_branch;

	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc_plus4 +
		{{14{instruction.i_view.imm16[15]}}, instruction.i_view.imm16, 2'b00};
	assign jump_target = {pc_plus4[31:28], instruction.i_view.rs, instruction.i_view.rt,
		instruction.i_view.imm16, 2'b00}; // 26-bit target field
	assign take_branch = ctrl.branch && (equal == ctrl.branch_on_equal);

	always_comb begin
		if (ctrl.jump_register) begin
			next_pc = register_target;
		end else if (ctrl.jump) begin
			next_pc = jump_target;
		end else if (take_branch) begin
			next_pc = branch_target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_VECTOR;
		end else begin
			pc <= next_pc;
		end
	end

	// Catches a misaligned jr target from the register file
	assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("misaligned pc %h", pc);
endmodule

// File: design/hi_lo_unit.sv
`timescale 1ns/100ps

module hi_lo_unit (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] a,
	input  logic [31:0] b,
	ctrl_if.use_side    ctrl,
	output logic [31:0] hi_lo_value
);
	logic [63:0] product;
	logic [31:0] hi;
	logic [31:0] lo;

	always_comb begin
		if (ctrl.multiply_signed) begin
			product = 64'($signed(a)) * 64'($signed(b)); // Operands sign extend to 64 bits
		end else begin
			product = {32'h0000_0000, a} * {32'h0000_0000, b};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hi <= 32'h0000_0000;
			lo <= 32'h0000_0000;
		end else if (ctrl.hi_lo_write) begin
			hi <= product[63:32];
			lo <= product[31:0];
		end
	end

	assign hi_lo_value = ctrl.read_hi ? hi : lo;
endmodule

// File: design/register_file.sv
`timescale 1ns/100ps

module register_file (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  read_reg_a,
	input  logic [4:0]  read_reg_b,
	input  logic [4:0]  write_reg,
	input  logic        write_enable,
	input  logic [31:0] write_data,
	output logic [31:0] read_data_a,
	output logic [31:0] read_data_b
);
	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'h0000_0000;
			end
		end else if (write_enable && write_reg != 5'd0) begin // $0 stays zero
			regs[write_reg] <= write_data;
		end
	end

	assign read_data_a = (read_reg_a == 5'd0) ? 32'h0000_0000 : regs[read_reg_a];
	assign read_data_b = (read_reg_b == 5'd0) ? 32'h0000_0000 : regs[read_reg_b];

	// Write-back mux must settle on a known value
	assert property (@(posedge clk) disable iff (rst) write_enable |-> !$isunknown(write_data))
		else $error("unknown write-back data to register %0d", write_reg);
endmodule

// File: design/alu.sv
`timescale 1ns/100ps

module alu (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	input  logic [3:0]  op,
	output logic [31:0] result,
	output logic        equal
);
	always_comb begin
		case (op)
			mips_pkg::ALU_ADD:  result = a + b;
			mips_pkg::ALU_SUB:  result = a - b;
			mips_pkg::ALU_AND:  result = a & b;
			mips_pkg::ALU_OR:   result = a | b;
			mips_pkg::ALU_XOR:  result = a ^ b;
			mips_pkg::ALU_NOR:  result = ~(a | b);
			mips_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
			mips_pkg::ALU_SLTU: result = {31'b0, a < b};
			mips_pkg::ALU_SLL:  result = b << shamt;  // Shifts act on rt
			mips_pkg::ALU_SRL:  result = b >> shamt;
			mips_pkg::ALU_SRA:  result = $signed(b) >>> shamt;
			mips_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
			default:            result = 32'h0000_0000;
		endcase
	end

	assign equal = (a == b); // Branch compare of rs and rt
endmodule

// File: design/control_unit.sv
`timescale 1ns/100ps

module control_unit (
	input mips_pkg::instr_word_t instruction,
	ctrl_if.decode               ctrl
);
	logic [3:0] funct_op;
	logic       illegal_op;

	always_comb begin
		case (instruction.r_view.funct)
			mips_pkg::FN_SUBU: funct_op = mips_pkg::ALU_SUB;
			mips_pkg::FN_AND:  funct_op = mips_pkg::ALU_AND;
			mips_pkg::FN_OR:   funct_op = mips_pkg::ALU_OR;
			mips_pkg::FN_XOR:  funct_op = mips_pkg::ALU_XOR;
			mips_pkg::FN_NOR:  funct_op = mips_pkg::ALU_NOR;
			mips_pkg::FN_SLT:  funct_op = mips_pkg::ALU_SLT;
			mips_pkg::FN_SLTU: funct_op = mips_pkg::ALU_SLTU;
			mips_pkg::FN_SLL:  funct_op = mips_pkg::ALU_SLL;
			mips_pkg::FN_SRL:  funct_op = mips_pkg::ALU_SRL;
			mips_pkg::FN_SRA:  funct_op = mips_pkg::ALU_SRA;
			default:           funct_op = mips_pkg::ALU_ADD; // addu
		endcase
	end

	always_comb begin
		ctrl.register_write       = 1'b0;
		ctrl.memory_to_register   = 1'b0;
		ctrl.memory_write         = 1'b0;
		ctrl.alu_src_a_shamt      = 1'b0;
		ctrl.alu_src_b            = mips_pkg::SRC_B_REG;
		ctrl.register_destination = mips_pkg::DEST_RT;
		ctrl.branch               = 1'b0;
		ctrl.branch_on_equal      = 1'b0;
		ctrl.jump                 = 1'b0;
		ctrl.jump_register        = 1'b0;
		ctrl.link                 = 1'b0;
		ctrl.hi_lo_write          = 1'b0;
		ctrl.multiply_signed      = 1'b0;
		ctrl.read_hi_lo           = 1'b0;
		ctrl.read_hi              = 1'b0;
		ctrl.zero_extend          = 1'b0;
		ctrl.alu_op               = mips_pkg::ALU_ADD;
		illegal_op                = 1'b0;
		case (instruction.i_view.op)
			mips_pkg::OP_RTYPE: begin
				case (instruction.r_view.funct)
					mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
						ctrl.register_write       = 1'b1;
						ctrl.register_destination = mips_pkg::DEST_RD;
						ctrl.alu_src_a_shamt      = 1'b1;
						ctrl.alu_op               = funct_op;
					end
					mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR,
					mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLT, mips_pkg::FN_SLTU: begin
						ctrl.register_write       = 1'b1;
						ctrl.register_destination = mips_pkg::DEST_RD;
						ctrl.alu_op               = funct_op;
					end
					mips_pkg::FN_JR: ctrl.jump_register = 1'b1;
					mips_pkg::FN_JALR: begin
						ctrl.register_write       = 1'b1;
						ctrl.register_destination = mips_pkg::DEST_RD;
						ctrl.alu_src_b            = mips_pkg::SRC_B_PC4;
						ctrl.jump_register        = 1'b1;
						ctrl.link                 = 1'b1;
					end
					mips_pkg::FN_MULT: begin
						ctrl.hi_lo_write     = 1'b1;
						ctrl.multiply_signed = 1'b1;
					end
					mips_pkg::FN_MULTU: ctrl.hi_lo_write = 1'b1;
					mips_pkg::FN_MFHI, mips_pkg::FN_MFLO: begin
						ctrl.register_write       = 1'b1;
						ctrl.register_destination = mips_pkg::DEST_RD;
						ctrl.read_hi_lo           = 1'b1;
						ctrl.read_hi = (instruction.r_view.funct == mips_pkg::FN_MFHI);
					end
					default: ; // Unknown function, nothing active
				endcase
			end
			mips_pkg::OP_J: ctrl.jump = 1'b1;
			mips_pkg::OP_JAL: begin
				ctrl.register_write       = 1'b1;
				ctrl.register_destination = mips_pkg::DEST_RA;
				ctrl.alu_src_b            = mips_pkg::SRC_B_PC4;
				ctrl.jump                 = 1'b1;
				ctrl.link                 = 1'b1;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				ctrl.branch          = 1'b1;
				ctrl.branch_on_equal = (instruction.i_view.op == mips_pkg::OP_BEQ);
				ctrl.alu_op          = mips_pkg::ALU_SUB;
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_LUI,
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LW: begin
				ctrl.register_write     = 1'b1;
				ctrl.alu_src_b          = mips_pkg::SRC_B_IMM;
				ctrl.memory_to_register = (instruction.i_view.op == mips_pkg::OP_LW);
				case (instruction.i_view.op)
					mips_pkg::OP_SLTI:  ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::OP_SLTIU: ctrl.alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::OP_LUI:   ctrl.alu_op = mips_pkg::ALU_LUI;
					mips_pkg::OP_ANDI:  ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::OP_ORI:   ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::OP_XORI:  ctrl.alu_op = mips_pkg::ALU_XOR;
					default:            ctrl.alu_op = mips_pkg::ALU_ADD; // addiu, lw
				endcase
				ctrl.zero_extend = (instruction.i_view.op == mips_pkg::OP_ANDI) ||
				                   (instruction.i_view.op == mips_pkg::OP_ORI) ||
				                   (instruction.i_view.op == mips_pkg::OP_XORI);
			end
			mips_pkg::OP_SW: begin
				ctrl.memory_write = 1'b1;
				ctrl.alu_src_b    = mips_pkg::SRC_B_IMM;
			end
			default: illegal_op = 1'b1; // Controls stay inactive
		endcase
	end

	// Fetched word must decode once the core runs
	assert property (@(posedge ctrl.clk) disable iff (ctrl.rst) !illegal_op)
		else $error("unsupported opcode %b", instruction.r_view.op);
endmodule

// File: design/ctrl_if.sv
`timescale 1ns/100ps

interface ctrl_if (
	input logic clk,
	input logic rst
);
	logic       register_write;
	logic       memory_to_register;
	logic       memory_write;
	logic       alu_src_a_shamt;      // Shift by instruction shamt
	logic [1:0] alu_src_b;
	logic [1:0] register_destination;
	logic       branch;
	logic       branch_on_equal;
	logic       jump;
	logic       jump_register;
	logic       link;                 // Write back PC+4
	logic       hi_lo_write;
	logic       multiply_signed;
	logic       read_hi_lo;
	logic       read_hi;
	logic       zero_extend;
	logic [3:0] alu_op;

	modport decode (
		input  clk, rst,
		output register_write, memory_to_register, memory_write, alu_src_a_shamt,
		output alu_src_b, register_destination, branch, branch_on_equal, jump,
		output jump_register, link, hi_lo_write, multiply_signed, read_hi_lo,
		output read_hi, zero_extend, alu_op
	);

	modport use_side (
		input register_write, memory_to_register, memory_write, alu_src_a_shamt,
		input alu_src_b, register_destination, branch, branch_on_equal, jump,
		input jump_register, link, hi_lo_write, multiply_signed, read_hi_lo,
		input read_hi, zero_extend, alu_op
	);
endinterface

// File: design/mips_pkg.sv
package mips_pkg;
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_JAL   = 6'b000011;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_BNE   = 6'b000101;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI  = 6'b001010;
	localparam logic [5:0] OP_SLTIU = 6'b001011;
	localparam logic [5:0] OP_ANDI  = 6'b001100;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;

	localparam logic [5:0] FN_SLL   = 6'b000000;
	localparam logic [5:0] FN_SRL   = 6'b000010;
	localparam logic [5:0] FN_SRA   = 6'b000011;
	localparam logic [5:0] FN_JR    = 6'b001000;
	localparam logic [5:0] FN_JALR  = 6'b001001;
	localparam logic [5:0] FN_MFHI  = 6'b010000;
	localparam logic [5:0] FN_MFLO  = 6'b010010;
	localparam logic [5:0] FN_MULT  = 6'b011000;
	localparam logic [5:0] FN_MULTU = 6'b011001;
	localparam logic [5:0] FN_ADDU  = 6'b100001;
	localparam logic [5:0] FN_SUBU  = 6'b100011;
	localparam logic [5:0] FN_AND   = 6'b100100;
	localparam logic [5:0] FN_OR    = 6'b100101;
	localparam logic [5:0] FN_XOR   = 6'b100110;
	localparam logic [5:0] FN_NOR   = 6'b100111;
	localparam logic [5:0] FN_SLT   = 6'b101010;
	localparam logic [5:0] FN_SLTU  = 6'b101011;

	localparam logic [3:0] ALU_ADD  = 4'd0;
	localparam logic [3:0] ALU_SUB  = 4'd1;
	localparam logic [3:0] ALU_AND  = 4'd2;
	localparam logic [3:0] ALU_OR   = 4'd3;
	localparam logic [3:0] ALU_XOR  = 4'd4;
	localparam logic [3:0] ALU_NOR  = 4'd5;
	localparam logic [3:0] ALU_SLT  = 4'd6;
	localparam logic [3:0] ALU_SLTU = 4'd7;
	localparam logic [3:0] ALU_SLL  = 4'd8;
	localparam logic [3:0] ALU_SRL  = 4'd9;
	localparam logic [3:0] ALU_SRA  = 4'd10;
	localparam logic [3:0] ALU_LUI  = 4'd11;

	localparam logic [1:0] SRC_B_REG = 2'd0;
	localparam logic [1:0] SRC_B_IMM = 2'd1;
	localparam logic [1:0] SRC_B_PC4 = 2'd2;

	localparam logic [1:0] DEST_RT = 2'd0;
	localparam logic [1:0] DEST_RD = 2'd1;
	localparam logic [1:0] DEST_RA = 2'd2; // Link register $31

	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r_view;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm16;
		} i_view;
	} instr_word_t;
endpackage
